/* dv/cart_assert.sv */
/*
 * protocol assertions for the cartridge bridge top
 * reset state, request and response exclusivity, bus data hold
 * bind of the checker into cart_top
 */

module cart_assert (
	input logic                 clk42,
	input logic                 w_n_reset,
	input logic                 is_output,
	input logic [7:0]           data_out,
	input cart_pkg::bus_req_t   req,
	input cart_pkg::read_resp_t gpio_resp,
	input cart_pkg::read_resp_t ram_resp
);
	// failed assertions, read by the testbench for its verdict
	int assert_errors = 0;

	// bus released while reset is held
	reset_idle: assert property (@(posedge clk42) !w_n_reset |=> !is_output)
		else begin
			assert_errors++;
			$error("is_output high during reset");
		end

	// single cycle pulses, never read and write together
	req_exclusive: assert property (@(posedge clk42) disable iff (!w_n_reset)
		!(req.read && req.write) && !(req.read && $past(req.read))
		&& !(req.write && $past(req.write)))
		else begin
			assert_errors++;
			$error("request with read and write together or longer than one cycle");
		end

	// only the addressed device answers
	one_responder: assert property (@(posedge clk42) disable iff (!w_n_reset)
		!(gpio_resp.ready && ram_resp.ready))
		else begin
			assert_errors++;
			$error("two read responses in one cycle");
		end

	// driven byte holds until the bus is released
	data_hold: assert property (@(posedge clk42) disable iff (!w_n_reset)
		is_output |=> (!is_output || $stable(data_out)))
		else begin
			assert_errors++;
			$error("data_out changed while driving the bus");
		end

endmodule

bind cart_top cart_assert u_assert (
	.clk42     (clk42),
	.w_n_reset (w_n_reset),
	.is_output (is_output),
	.data_out  (data_out),
	.req       (req),
	.gpio_resp (gpio_resp),
	.ram_resp  (ram_resp)
);

/* dv/cart_tb.sv */
/*
 * testbench for the cartridge bridge
 * clock, reset, random msx bus cycles against a model
 * of ram, gpio and sound level, pwm duty count, watchdog
 */

`include "cart_config.svh"

module cart_tb;
	localparam int PERIOD = 256 * `CART_PWM_PRESCALE;
	localparam int N_RAM = 120;
	localparam int N_UNMAP = 16;
	localparam int N_IO = 24;
	// 17 clocks per bus cycle, rounded up
	localparam int BUS_CYCLES = 2 * N_RAM + 6 * N_UNMAP + 5 * N_IO + 1;
	localparam longint WATCHDOG_TIME = (BUS_CYCLES * 20 + 6 * PERIOD + 100) * 20;

	logic clk42, w_n_reset, n_sltsl, n_rd, n_wr, n_iorq, n_merq, is_output, snd;
	logic [15:0] adr;
	logic [7:0]  data_in, gpi, data_out, gpo;
	// reference model state
	logic [7:0]  ram_model [2 ** `CART_RAM_ADDR_BITS];
	logic [7:0]  gpo_model, level_model, gpi_model;
	int          mismatch_errors, other_errors;

	cart_top dut (.*);

	always #10 clk42 = ~clk42;

	task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual,
		input string msg);
		if (actual !== expected) begin
			mismatch_errors++;
			$display("mismatch at %0t: %s, expected %0h, got %0h", $time, msg, expected, actual);
		end
	endtask

	// ---------------------------------------------------
	// one bus cycle, strobe low 12 clocks then 4 idle
	// ---------------------------------------------------
	task automatic bus_cycle(input logic is_rd, input logic is_io, input logic slot,
		input logic [15:0] a, input logic [7:0] wd, output logic [7:0] rd, output int rise_at);
		rise_at = 0;
		rd = 8'h00;
		@(negedge clk42);
		adr = a;
		data_in = wd;
		n_sltsl = ~slot;
		n_iorq = ~is_io;
		n_merq = is_io;
		n_rd = ~is_rd;
		n_wr = is_rd;
		for (int i = 1; i <= 12; i++) begin
			@(negedge clk42);
			// first cycle seen driving, keep its byte
			if (is_output && rise_at == 0) begin
				rise_at = i;
				rd = data_out;
			end
		end
		{n_rd, n_wr, n_iorq, n_merq, n_sltsl} = 5'b11111;
		repeat (4) @(negedge clk42);
		if (is_output) begin
			other_errors++;
			$display("bus still driven 4 cycles after the strobe ended, address %04h", a);
		end
	endtask

	task automatic write_cycle(input logic is_io, input logic slot, input logic [15:0] a,
		input logic [7:0] d);
		logic [7:0] unused;
		int rise_at;
		bus_cycle(1'b0, is_io, slot, a, d, unused, rise_at);
	endtask

	task automatic expect_read(input logic is_io, input logic slot, input logic [15:0] a,
		input logic [7:0] expected, input string what);
		logic [7:0] got;
		int rise_at;
		bus_cycle(1'b1, is_io, slot, a, 8'h00, got, rise_at);
		if (rise_at == 0 || rise_at > 10) begin
			other_errors++;
			$display("%s at %04h was not driven within 10 cycles of the strobe", what, a);
		end else begin
			check_equal(expected, got, what);
		end
	endtask

	task automatic expect_no_read(input logic is_io, input logic slot, input logic [15:0] a);
		logic [7:0] got;
		int rise_at;
		bus_cycle(1'b1, is_io, slot, a, 8'h00, got, rise_at);
		if (rise_at != 0) begin
			other_errors++;
			$display("read of unmapped address %04h drove the bus", a);
		end
	endtask

	// run limit from the test lengths above
	initial begin
		#(WATCHDOG_TIME);
		$display("timeout, the tests did not finish in %0d time units", WATCHDOG_TIME);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int          high_cnt;
		int          idx;
		logic [13:0] off;
		logic [7:0]  val;
		logic [7:0]  port;
		logic [1:0]  pg;
		logic        prev_snd;
		logic        found;
		logic [13:0] written_q [$];
		clk42 = 0;
		w_n_reset = 0;
		adr = '0;
		data_in = '0;
		gpi = '0;
		{n_rd, n_wr, n_iorq, n_merq, n_sltsl} = 5'b11111;
		mismatch_errors = 0;
		other_errors = 0;
		void'($urandom(32'h9ead));
		repeat (16) @(negedge clk42);
		w_n_reset = 1;
		gpo_model = 8'h00;
		level_model = 8'h00;

		// after reset, quiet outputs over a whole pwm period
		check_equal(0, is_output, "is_output after reset");
		check_equal(0, data_out, "data_out after reset");
		check_equal(gpo_model, gpo, "gpo after reset");
		high_cnt = 0;
		repeat (PERIOD) begin
			@(negedge clk42);
			if (snd) high_cnt++;
		end
		check_equal(0, high_cnt, "snd high cycles after reset");

		// ---------------------------------------------------
		// ram window, random writes and readback
		// ---------------------------------------------------
		repeat (N_RAM) begin
			off = 14'($urandom);
			val = 8'($urandom);
			write_cycle(1'b0, 1'b1, {`CART_RAM_PAGE, off}, val);
			ram_model[off] = val;
			written_q.push_back(off);
			idx = $urandom % written_q.size();
			off = written_q[idx];
			expect_read(1'b0, 1'b1, {`CART_RAM_PAGE, off}, ram_model[off], "ram read");
		end

		// unmapped pages and foreign slot alias the same offset
		repeat (N_UNMAP) begin
			off = 14'($urandom);
			val = 8'($urandom);
			pg = 2'($urandom % 3);
			if (pg == `CART_RAM_PAGE) pg = 2'b11;
			write_cycle(1'b0, 1'b1, {`CART_RAM_PAGE, off}, val);
			ram_model[off] = val;
			write_cycle(1'b0, 1'b1, {pg, off}, ~val);
			write_cycle(1'b0, 1'b0, {`CART_RAM_PAGE, off}, val ^ 8'h5a);
			expect_no_read(1'b0, 1'b1, {pg, off});
			expect_no_read(1'b0, 1'b0, {`CART_RAM_PAGE, off});
			expect_read(1'b0, 1'b1, {`CART_RAM_PAGE, off}, ram_model[off], "ram after alias");
		end

		// ---------------------------------------------------
		// io ports, high address byte is don't care
		// ---------------------------------------------------
		repeat (N_IO) begin
			gpo_model = 8'($urandom);
			write_cycle(1'b1, 1'b0, {8'($urandom), `CART_GPIO_PORT}, gpo_model);
			check_equal(gpo_model, gpo, "gpo after port write");
			gpi_model = 8'($urandom);
			gpi = gpi_model;
			expect_read(1'b1, 1'b0, {8'($urandom), `CART_GPIO_PORT}, gpi_model, "gpi read");
			level_model = 8'($urandom);
			write_cycle(1'b1, 1'b0, {8'($urandom), `CART_SOUND_PORT}, level_model);
			expect_read(1'b1, 1'b0, {8'h00, `CART_SOUND_PORT}, level_model, "sound readback");
			port = 8'($urandom);
			if (port == `CART_GPIO_PORT || port == `CART_SOUND_PORT) port = 8'h12;
			expect_no_read(1'b1, 1'b0, {8'h00, port});
		end

		// sound duty, nonzero level so every period has a rising edge
		level_model = 8'(1 + $urandom % 255);
		write_cycle(1'b1, 1'b0, {8'h00, `CART_SOUND_PORT}, level_model);
		repeat (2 * PERIOD) @(negedge clk42);
		prev_snd = snd;
		found = 0;
		while (!found) begin
			@(negedge clk42);
			found = !prev_snd && snd;
			prev_snd = snd;
		end
		high_cnt = 1;
		repeat (PERIOD - 1) begin
			@(negedge clk42);
			if (snd) high_cnt++;
		end
		check_equal(level_model * `CART_PWM_PRESCALE, high_cnt, "snd high cycles per period");

		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_errors, other_errors, dut.u_assert.assert_errors);
		if (mismatch_errors == 0 && other_errors == 0 && dut.u_assert.assert_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+logic
logic/cart_pkg.sv
logic/msx_bus_decode.sv
logic/io_ports.sv
logic/cart_ram.sv
logic/read_response.sv
logic/sound_pwm.sv
logic/cart_top.sv
dv/cart_assert.sv
dv/cart_tb.sv

/* logic/cart_config.svh */
/*
 * cartridge build constants
 * i/o port numbers, ram window select, strobe synchronizer depth
 * and the pwm prescale count
 */

`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// --------------------------------------------------
// i/o ports
// --------------------------------------------------
// gpio register, writes drive gpo and reads return gpi
`define CART_GPIO_PORT 8'h10
// sound level register, read back as written
`define CART_SOUND_PORT 8'h11

// --------------------------------------------------
// memory window
// --------------------------------------------------
// adr[15:14] of the 8000h-bfffh page
`define CART_RAM_PAGE 2'b10
// offset bits inside the window, 16 KB
`define CART_RAM_ADDR_BITS 14

// flops per bus strobe before edge detection
`define CART_SYNC_STAGES 2
// clk42 cycles per pwm phase step, about 1.6 MHz
`define CART_PWM_PRESCALE 27

`endif

/* logic/cart_pkg.sv */
/*
 * shared bus types of the cartridge bridge
 * bus_req_t is one decoded msx bus cycle
 * read_resp_t is a device answer to a read request
 */

package cart_pkg;

	// --------------------------------------------------
	// decoded bus cycle
	// --------------------------------------------------
	// read and write are single cycle pulses
	// never both set in one cycle
	typedef struct packed {
		// full z80 address, low byte is the i/o port
		logic [15:0] address;
		// data captured at the write strobe edge
		logic [7:0]  wdata;
		logic        read;
		logic        write;
		// n_iorq was low
		logic        io;
		// n_merq and n_sltsl were low
		logic        memory;
	} bus_req_t;

	// --------------------------------------------------
	// read answer
	// --------------------------------------------------
	// data is zero unless ready is set
	// so all device answers merge with a plain or
	typedef struct packed {
		logic       ready;
		logic [7:0] data;
	} read_resp_t;

endpackage

/* logic/cart_ram.sv */
/*
 * cartridge ram
 * 16 KB byte array at 8000h-bfffh of the cartridge slot
 * synchronous read with a one cycle response
 */

`include "cart_config.svh"

module cart_ram (
	input  logic                  clk42,
	input  logic                  w_n_reset,
	input  cart_pkg::bus_req_t    req,
	output cart_pkg::read_resp_t  resp
);
	localparam int DEPTH = 2 ** `CART_RAM_ADDR_BITS;

	logic [7:0]                     mem [DEPTH];
	logic [`CART_RAM_ADDR_BITS-1:0] offset;
	logic                           hit;
	logic [7:0]                     rdata_q;
	logic                           ready_q;

	// window select on the address bits above the offset
	assign offset = req.address[`CART_RAM_ADDR_BITS-1:0];
	assign hit    = req.memory & (req.address[15:`CART_RAM_ADDR_BITS] == `CART_RAM_PAGE);

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	// plain single port block ram pattern
	always_ff @(posedge clk42) begin
		if (req.write & hit) begin
			mem[offset] <= req.wdata;
		end
		rdata_q <= mem[offset];
	end

	// --------------------------------------------------
	// response
	// --------------------------------------------------
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= req.read & hit;
		end
	end

	// keep data zero while not answering so responses can be or-merged
	assign resp = '{ready: ready_q, data: ready_q ? rdata_q : 8'h00};

endmodule

/* logic/cart_top.sv */
/*
 * cartridge bridge top
 * bus decode, i/o ports, cartridge ram, read return path
 * and the sound pwm
 */

module cart_top (
	input  logic        clk42,
	input  logic        w_n_reset,
	input  logic [15:0] adr,
	input  logic [7:0]  data_in,
	input  logic        n_sltsl,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        n_iorq,
	input  logic        n_merq,
	input  logic [7:0]  gpi,
	output logic [7:0]  data_out,
	output logic        is_output,
	output logic [7:0]  gpo,
	output logic        snd
);
	cart_pkg::bus_req_t   req;
	cart_pkg::read_resp_t gpio_resp;
	cart_pkg::read_resp_t ram_resp;
	logic                 rd_active;
	logic [7:0]           sound_level;

	// --------------------------------------------------
	// decode
	// --------------------------------------------------
	msx_bus_decode u_decode (
		.clk42     (clk42),
		.w_n_reset (w_n_reset),
		.adr       (adr),
		.data_in   (data_in),
		.n_sltsl   (n_sltsl),
		.n_rd      (n_rd),
		.n_wr      (n_wr),
		.n_iorq    (n_iorq),
		.n_merq    (n_merq),
		.req       (req),
		.rd_active (rd_active)
	);

	// --------------------------------------------------
	// execute
	// --------------------------------------------------
	io_ports u_io_ports (
		.clk42       (clk42),
		.w_n_reset   (w_n_reset),
		.req         (req),
		.gpi         (gpi),
		.resp        (gpio_resp),
		.gpo         (gpo),
		.sound_level (sound_level)
	);

	cart_ram u_ram (
		.clk42     (clk42),
		.w_n_reset (w_n_reset),
		.req       (req),
		.resp      (ram_resp)
	);

	// --------------------------------------------------
	// result
	// --------------------------------------------------
	read_response u_read_response (
		.clk42     (clk42),
		.w_n_reset (w_n_reset),
		.gpio_resp (gpio_resp),
		.ram_resp  (ram_resp),
		.rd_active (rd_active),
		.data_out  (data_out),
		.is_output (is_output)
	);

	sound_pwm u_pwm (
		.clk42       (clk42),
		.w_n_reset   (w_n_reset),
		.sound_level (sound_level),
		.snd         (snd)
	);

endmodule

/* logic/io_ports.sv */
/*
 * i/o port registers
 * port 10h gpio, writes set gpo and reads return gpi
 * port 11h sound level, read and write
 */

`include "cart_config.svh"

module io_ports (
	input  logic                  clk42,
	input  logic                  w_n_reset,
	input  cart_pkg::bus_req_t    req,
	input  logic [7:0]            gpi,
	output cart_pkg::read_resp_t  resp,
	output logic [7:0]            gpo,
	output logic [7:0]            sound_level
);
	logic gpio_hit;
	logic sound_hit;

	// only the low address byte carries the port number
	assign gpio_hit  = req.io & (req.address[7:0] == `CART_GPIO_PORT);
	assign sound_hit = req.io & (req.address[7:0] == `CART_SOUND_PORT);

	// --------------------------------------------------
	// write side
	// --------------------------------------------------
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			gpo         <= 8'h00;
			sound_level <= 8'h00;
		end else if (req.write) begin
			if (gpio_hit) begin
				gpo <= req.wdata;
			end
			if (sound_hit) begin
				sound_level <= req.wdata;
			end
		end
	end

	// --------------------------------------------------
	// read side
	// --------------------------------------------------
	// answer one cycle after the request, zero data otherwise
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			resp <= '0;
		end else if (req.read & gpio_hit) begin
			resp <= '{ready: 1'b1, data: gpi};
		end else if (req.read & sound_hit) begin
			resp <= '{ready: 1'b1, data: sound_level};
		end else begin
			resp <= '0;
		end
	end

endmodule

/* logic/msx_bus_decode.sv */
/*
 * msx bus front end
 * strobe synchronizer, falling edge detect on n_rd and n_wr,
 * i/o or slot memory classification and single cycle requests
 */

`include "cart_config.svh"

module msx_bus_decode (
	input  logic                clk42,
	input  logic                w_n_reset,
	input  logic [15:0]         adr,
	input  logic [7:0]          data_in,
	input  logic                n_sltsl,
	input  logic                n_rd,
	input  logic                n_wr,
	input  logic                n_iorq,
	input  logic                n_merq,
	output cart_pkg::bus_req_t  req,
	output logic                rd_active
);
	// all active low strobes, sampled together
	typedef struct packed {
		logic n_rd;
		logic n_wr;
		logic n_iorq;
		logic n_merq;
		logic n_sltsl;
	} strobes_t;

	strobes_t [`CART_SYNC_STAGES-1:0] sync_q;
	strobes_t    synced;
	logic        rd_prev;
	logic        wr_prev;
	logic        rd_fall;
	logic        wr_fall;
	logic        cycle_io;
	logic        cycle_mem;
	logic        req_rd;
	logic        req_wr;
	logic [15:0] req_adr;
	logic [7:0]  req_wdata;
	logic        req_io;
	logic        req_mem;

	// --------------------------------------------------
	// synchronizer and edge detect
	// --------------------------------------------------
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			// idle bus, every strobe high
			sync_q  <= '1;
			rd_prev <= 1'b1;
			wr_prev <= 1'b1;
		end else begin
			sync_q[0] <= '{n_rd, n_wr, n_iorq, n_merq, n_sltsl};
			for (int i = 1; i < `CART_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			rd_prev <= synced.n_rd;
			wr_prev <= synced.n_wr;
		end
	end

	assign synced    = sync_q[`CART_SYNC_STAGES-1];
	assign rd_fall   = rd_prev & ~synced.n_rd;
	assign wr_fall   = wr_prev & ~synced.n_wr;
	assign cycle_io  = ~synced.n_iorq;
	assign cycle_mem = ~synced.n_merq & ~synced.n_sltsl;
	assign rd_active = ~synced.n_rd;

	// --------------------------------------------------
	// request issue
	// --------------------------------------------------
	// one pulse per edge, read wins a simultaneous edge
	// cycles outside our slot and not i/o are ignored
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			req_rd <= 1'b0;
			req_wr <= 1'b0;
		end else begin
			req_rd <= rd_fall & (cycle_io | cycle_mem);
			req_wr <= wr_fall & ~rd_fall & (cycle_io | cycle_mem);
		end
	end

	// address and data held stable by the bus while the strobe is low
	always_ff @(posedge clk42) begin
		if (rd_fall | wr_fall) begin
			req_adr   <= adr;
			req_wdata <= data_in;
			req_io    <= cycle_io;
			req_mem   <= cycle_mem;
		end
	end

	assign req = '{address: req_adr, wdata: req_wdata, read: req_rd,
		write: req_wr, io: req_io, memory: req_mem};

endmodule

/* logic/read_response.sv */
/*
 * read data return path
 * or-merge of device answers, data latch and bus drive enable
 * held until the synchronized read strobe ends
 */

module read_response (
	input  logic                  clk42,
	input  logic                  w_n_reset,
	input  cart_pkg::read_resp_t  gpio_resp,
	input  cart_pkg::read_resp_t  ram_resp,
	input  logic                  rd_active,
	output logic [7:0]            data_out,
	output logic                  is_output
);
	logic       any_ready;
	logic [7:0] merged_data;

	// --------------------------------------------------
	// merge
	// --------------------------------------------------
	// idle devices hold zero data
	assign any_ready   = gpio_resp.ready | ram_resp.ready;
	assign merged_data = gpio_resp.data | ram_resp.data;

	// --------------------------------------------------
	// bus drive
	// --------------------------------------------------
	// release as soon as n_rd is seen high again
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			data_out  <= 8'h00;
			is_output <= 1'b0;
		end else if (!rd_active) begin
			data_out  <= 8'h00;
			is_output <= 1'b0;
		end else if (any_ready) begin
			// latched value stays until the strobe ends
			data_out  <= merged_data;
			is_output <= 1'b1;
		end
	end

endmodule

/* logic/sound_pwm.sv */
/*
 * sound output
 * prescaler enable, 8 bit phase counter and a level register
 * reloaded at every period start
 */

`include "cart_config.svh"

module sound_pwm (
	input  logic       clk42,
	input  logic       w_n_reset,
	input  logic [7:0] sound_level,
	output logic       snd
);
	localparam int PRESCALE_W = $clog2(`CART_PWM_PRESCALE);
	localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(`CART_PWM_PRESCALE - 1);

	logic [PRESCALE_W-1:0] prescale_q;
	logic                  step_en;
	logic [7:0]            phase_q;
	logic [7:0]            level_q;

	// --------------------------------------------------
	// prescaler
	// --------------------------------------------------
	// down counter, one enable per wrap
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			prescale_q <= PRESCALE_LAST;
		end else if (prescale_q == '0) begin
			prescale_q <= PRESCALE_LAST;
		end else begin
			prescale_q <= prescale_q - 1'b1;
		end
	end

	assign step_en = (prescale_q == '0);

	// --------------------------------------------------
	// phase and level
	// --------------------------------------------------
	always_ff @(posedge clk42) begin
		if (!w_n_reset) begin
			phase_q <= 8'h00;
			level_q <= 8'h00;
			snd     <= 1'b0;
		end else begin
			if (step_en) begin
				phase_q <= phase_q + 8'd1;
				// new level only at the wrap, duty constant over a period
				if (phase_q == 8'hff) begin
					level_q <= sound_level;
				end
			end
			// registered compare, glitch free pin
			snd <= (phase_q < level_q);
		end
	end

endmodule
